// File: Makefile
VERILATOR ?= verilator
TOP ?= routerTb
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= ALL TESTS PASSED
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: arbPkg.sv
package arbPkg;

  localparam int NUM_PORTS = 5;

  typedef logic [2:0] portIdx_t;

  // Bit 0 is L, then N, E, W, and bit 4 is S.
  typedef logic [NUM_PORTS-1:0] portMask_t;

  // One-hot arbiter states. GRANT_p sits at bit p+1.
  typedef enum logic [5:0] {
    IDLE    = 6'b000001,
    GRANT_L = 6'b000010,
    GRANT_N = 6'b000100,
    GRANT_E = 6'b001000,
    GRANT_W = 6'b010000,
    GRANT_S = 6'b100000
  } arbState_t;

endpackage

// File: crossbar.sv
module crossbar
  import flitPkg::*;
  import arbPkg::*;
(
  input logic clk,
  input logic rst,
  portIf.dst ports [NUM_PORTS],
  output flit_t outFlit,
  output logic outValid
);

  portMask_t grantVec;
  flit_t masked [NUM_PORTS];
  flit_t selFlit;

  for (genvar i = 0; i < NUM_PORTS; i++)
  begin : genSel
    assign grantVec[i] = ports[i].grant;
    assign masked[i] = {FLIT_W{ports[i].grant}} & ports[i].headFlit;
  end

  // Grants are one-hot, so an OR of the masked flits is the mux.
  always_comb
  begin
    selFlit = '0;
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      selFlit = selFlit | masked[i];
    end
  end

  always_ff @(posedge clk)
  begin
    outFlit <= selFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= |grantVec;
    end
  end

endmodule

// File: flitPkg.sv
package flitPkg;

  localparam int FLIT_W = 16;
  localparam int ID_W = 3;
  localparam int LEN_W = 12;

  typedef logic [FLIT_W-1:0] flit_t;

  // The flit type is taken from bits 15 to 13.
  typedef logic [ID_W-1:0] flitId_t;

  // The turn length is taken from bits 11 to 0 of a header flit.
  typedef logic [LEN_W-1:0] pktLen_t;

  // One-hot flit type codes.
  localparam flitId_t HEADER_ID = 3'd1;
  localparam flitId_t BODY_ID = 3'd2;
  localparam flitId_t TAIL_ID = 3'd4;

endpackage

// File: holdTimer.sv
module holdTimer
  import flitPkg::*;
(
  input logic clk,
  input logic rst,
  input logic isHeader,
  input logic hold,
  input pktLen_t length,
  output logic timesUp
);

  pktLen_t turnLen;
  pktLen_t count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      turnLen <= '0;
      count <= '0;
    end
    else
    begin
      // A header at the head sets the length of the coming turn.
      if (isHeader)
      begin
        turnLen <= length;
      end
      if (hold)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0;
      end
    end
  end

  assign timesUp = (count == turnLen);

endmodule

// File: inputPort.sv
module inputPort
  import flitPkg::*;
#(
  parameter int FIFO_DEPTH = 4
)
(
  input logic clk,
  input logic rst,
  input flit_t wrFlit,
  input logic wr,
  output logic full,
  portIf.src port
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  flit_t mem [FIFO_DEPTH];
  flit_t headFlit;
  logic [PTR_W-1:0] rdPtr;
  logic [PTR_W-1:0] wrPtr;
  logic [CNT_W-1:0] count;
  logic empty;
  logic push;
  logic pop;

  function automatic logic [PTR_W-1:0] nextPtr(logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1))
    begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty = (count == '0);
  assign full = (count == CNT_W'(FIFO_DEPTH));

  // Writes into a full FIFO are dropped here.
  assign push = wr && !full;
  assign pop = port.grant && !empty;

  assign headFlit = mem[rdPtr];
  assign port.headFlit = headFlit;
  assign port.req = !empty;
  assign port.flitId = headFlit[FLIT_W-1 -: ID_W];
  assign port.length = headFlit[LEN_W-1:0];

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wrPtr] <= wrFlit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
      begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (pop)
      begin
        rdPtr <= nextPtr(rdPtr);
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: portIf.sv
interface portIf
  import flitPkg::*;
();

  flit_t headFlit;
  logic req;
  flitId_t flitId;
  pktLen_t length;
  logic grant;

  // The input FIFO side.
  modport src (
    output headFlit, req, flitId, length,
    input grant
  );

  // The arbiter and crossbar side.
  modport dst (
    input headFlit, req, flitId, length,
    output grant
  );

endinterface

// File: routerChecker.sv
module routerChecker
  import arbPkg::*;
(
  input logic clk,
  input logic rst,
  input portMask_t grants,
  input portMask_t reqs,
  input logic outValid
);

  // Only one port may own the output link in a cycle.
  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grants))
    else $error("More than one grant is high: %b", grants);

  grantNeedsReq: assert property (@(posedge clk) disable iff (rst) (grants & ~reqs) == '0)
    else $error("A grant went to a port without a request: grants %b, reqs %b",
                grants, reqs);

  // The output register comes out of reset empty.
  quietAfterReset: assert property (@(posedge clk) rst |=> !outValid)
    else $error("outValid is high in the cycle after reset.");

endmodule

bind routerTop routerChecker routerChecker_i (
  .clk(clk),
  .rst(rst),
  .grants(crossbar_i.grantVec),
  .reqs(switchArbiter_i.reqVec),
  .outValid(outValid)
);

// File: routerTb.sv
module routerTb
  import flitPkg::*;
  import arbPkg::*;
();

  localparam int FIFO_DEPTH = 4;
  localparam int WAIT_LIMIT = 400;

  logic clk = 1'b0;
  logic rst;
  flit_t inFlit [NUM_PORTS];
  portMask_t inWrite;
  portMask_t inFull;
  flit_t outFlit;
  logic outValid;

  integer seed = 32'h4519;
  flit_t stage [NUM_PORTS];
  flit_t expQ [NUM_PORTS][$];
  int srcLog [$];
  int rxCount = 0;

  routerTop #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) routerTop_i (
    .clk(clk),
    .rst(rst),
    .inFlit(inFlit),
    .inWrite(inWrite),
    .inFull(inFull),
    .outFlit(outFlit),
    .outValid(outValid)
  );

  initial
  begin
    forever #2 clk = ~clk;
  end

  task automatic stopRun();
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic reportProblem(input string what);
    $display("%s", what);
    stopRun();
  endtask

  task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
    if (actual !== expected)
    begin
      $display("[FAIL] %0t: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
      stopRun();
    end
  endtask

  function automatic flit_t makeHeader(int len);
    return {HEADER_ID, 1'b0, pktLen_t'(len)};
  endfunction

  // Body and tail flits carry their source port in bits 12 to 10.
  function automatic flit_t makeData(flitId_t id, int port);
    logic [9:0] payload;
    payload = 10'($random(seed));
    return {id, 3'(port), payload};
  endfunction

  // A header has no port tag, so it belongs to the port whose next expected flit it is.
  function automatic int sourceOf(flit_t f);
    int src;
    src = -1;
    if (f[15:13] == HEADER_ID)
    begin
      for (int p = 0; p < NUM_PORTS; p++)
        if (src < 0 && expQ[p].size() > 0 && expQ[p][0] == f)
          src = p;
    end
    else
      src = int'(f[12:10]);
    return src;
  endfunction

  function automatic bit queuesEmpty();
    for (int p = 0; p < NUM_PORTS; p++)
      if (expQ[p].size() != 0)
        return 1'b0;
    return 1'b1;
  endfunction

  always @(posedge clk)
  begin : monitor
    int src;
    if (!rst && outValid)
    begin
      src = sourceOf(outFlit);
      if (src < 0 || src >= NUM_PORTS)
        reportProblem($sformatf("Output flit 0x%0h at time %0t matches no input port.",
                                outFlit, $time));
      else if (expQ[src].size() == 0)
        reportProblem($sformatf("Port %0d sent flit 0x%0h that was never accepted.",
                                src, outFlit));
      else
      begin
        checkEq(32'(outFlit), 32'(expQ[src][0]), $sformatf("flit from port %0d", src));
        void'(expQ[src].pop_front());
        srcLog.push_back(src);
        rxCount++;
      end
    end
  end

  // Writes the staged flits of the ports in mask for one cycle.
  task automatic applyWrites(input portMask_t mask, input portMask_t keep);
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      inFlit[p] = stage[p];
      if (mask[p] && keep[p])
        expQ[p].push_back(stage[p]);
    end
    inWrite = mask;
    @(negedge clk);
    inWrite = '0;
  endtask

  task automatic waitDrain();
    int cycles;
    cycles = 0;
    while (!queuesEmpty())
    begin
      if (cycles >= WAIT_LIMIT)
        reportProblem("Timeout: written flits did not all reach the output link.");
      else
      begin
        @(negedge clk);
        cycles++;
      end
    end
  endtask

  task automatic waitQuiet();
    repeat (8)
    begin
      @(negedge clk);
      checkEq(32'(outValid), 32'd0, "outValid once all flits are out");
    end
  endtask

  task automatic resetState();
    repeat (10)
    begin
      @(negedge clk);
      checkEq(32'(outValid), 32'd0, "outValid after reset");
      checkEq(32'(inFull), 32'd0, "inFull after reset");
    end
  endtask

  task automatic singlePacket();
    srcLog.delete();
    for (int k = 0; k < 4; k++)
    begin
      stage[1] = (k == 0) ? makeHeader(4) : makeData((k == 3) ? TAIL_ID : BODY_ID, 1);
      applyWrites(5'b00010, 5'b00010);
    end
    waitDrain();
    checkEq(32'(srcLog.size()), 32'd4, "flit count of the N packet");
    foreach (srcLog[i])
      checkEq(32'(srcLog[i]), 32'd1, "source of a single packet flit");
    waitQuiet();
  endtask

  task automatic idlePriority();
    srcLog.delete();
    for (int p = 0; p < NUM_PORTS; p++)
      stage[p] = makeHeader(p + 1);
    applyWrites('1, '1);
    for (int p = 0; p < NUM_PORTS; p++)
      stage[p] = makeData(TAIL_ID, p);
    applyWrites('1, '1);
    waitDrain();
    checkEq(32'(srcLog.size()), 32'd10, "flit count of the idle priority test");
    checkEq(32'(srcLog[0]), 32'd0, "first source after idle");
    waitQuiet();
  endtask

  task automatic turnRotation();
    int lens [NUM_PORTS] = '{2, 3, 1, 4, 5};
    int rem [NUM_PORTS] = '{4, 4, 4, 4, 4};
    int model [$];
    int cur;
    int pick;
    int n;
    srcLog.delete();
    for (int k = 0; k < 4; k++)
    begin
      for (int p = 0; p < NUM_PORTS; p++)
        stage[p] = (k == 0) ? makeHeader(lens[p]) :
                              makeData((k == 3) ? TAIL_ID : BODY_ID, p);
      applyWrites('1, '1);
    end
    // Each turn sends up to its length, then the next requester after the holder
    // gets the link. Starting as if S had held makes the first search begin at L.
    cur = NUM_PORTS - 1;
    while (model.size() < 4 * NUM_PORTS)
    begin
      pick = -1;
      for (int k = 1; k <= NUM_PORTS; k++)
        if (pick < 0 && rem[(cur + k) % NUM_PORTS] > 0)
          pick = (cur + k) % NUM_PORTS;
      n = (rem[pick] < lens[pick]) ? rem[pick] : lens[pick];
      repeat (n) model.push_back(pick);
      rem[pick] -= n;
      cur = pick;
    end
    waitDrain();
    checkEq(32'(srcLog.size()), 32'(model.size()), "flit count of the rotation test");
    foreach (model[i])
      checkEq(32'(srcLog[i]), 32'(model[i]), $sformatf("source of output flit %0d", i));
    waitQuiet();
  endtask

  task automatic fullAndDrop();
    int fromW;
    srcLog.delete();
    stage[0] = makeHeader(16);
    applyWrites(5'b00001, 5'b00001);
    // L keeps its turn while W fills up, so W is never granted here.
    for (int k = 0; k <= FIFO_DEPTH; k++)
    begin
      stage[0] = makeData(BODY_ID, 0);
      stage[3] = (k == 0) ? makeHeader(FIFO_DEPTH) : makeData(BODY_ID, 3);
      applyWrites(5'b01001, (k < FIFO_DEPTH) ? 5'b01001 : 5'b00001);
      checkEq(32'(inFull[3]), (k + 1 >= FIFO_DEPTH) ? 32'd1 : 32'd0, "inFull of W");
    end
    stage[0] = makeData(TAIL_ID, 0);
    applyWrites(5'b00001, 5'b00001);
    waitDrain();
    fromW = 0;
    foreach (srcLog[i])
      if (srcLog[i] == 3)
        fromW++;
    checkEq(32'(fromW), 32'(FIFO_DEPTH), "flits delivered by W");
    waitQuiet();
  endtask

  task automatic drainAll();
    flit_t pend [NUM_PORTS][$];
    portMask_t mask;
    logic [31:0] rnd;
    int flits;
    int total;
    int left;
    int cycles;
    int rxStart;
    total = 0;
    // Header lengths differ modulo 5 between ports, so no two ports share a header.
    for (int p = 0; p < NUM_PORTS; p++)
      for (int k = 0; k < 3; k++)
      begin
        flits = 1 + ($random(seed) & 3);
        pend[p].push_back(makeHeader(1 + p + 5 * ($random(seed) & 1)));
        for (int j = 1; j < flits; j++)
          pend[p].push_back(makeData((j == flits - 1) ? TAIL_ID : BODY_ID, p));
        total += flits;
      end
    rxStart = rxCount;
    left = total;
    cycles = 0;
    while (left > 0)
    begin
      if (cycles >= WAIT_LIMIT)
        reportProblem("Timeout: the random packets could not all be written.");
      else
      begin
        rnd = $random(seed);
        mask = '0;
        for (int p = 0; p < NUM_PORTS; p++)
          if (pend[p].size() > 0 && !inFull[p] && rnd[p])
          begin
            stage[p] = pend[p].pop_front();
            mask[p] = 1'b1;
            left--;
          end
        applyWrites(mask, mask);
        cycles++;
      end
    end
    waitDrain();
    checkEq(32'(rxCount - rxStart), 32'(total), "total flits of the random mix");
    waitQuiet();
  endtask

  initial
  begin
    rst = 1'b1;
    inWrite = '0;
    foreach (inFlit[p])
      inFlit[p] = '0;
    foreach (stage[p])
      stage[p] = '0;
    repeat (3) @(negedge clk);
    rst = 1'b0;
    resetState();
    singlePacket();
    idlePriority();
    turnRotation();
    fullAndDrop();
    drainAll();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: routerTop.sv
module routerTop
  import flitPkg::*;
  import arbPkg::*;
#(
  parameter int FIFO_DEPTH = 4
)
(
  input logic clk,
  input logic rst,
  input flit_t inFlit [NUM_PORTS],
  input portMask_t inWrite,
  output portMask_t inFull,
  output flit_t outFlit,
  output logic outValid
);

  // Links are indexed by input port in the order L, N, E, W, S.
  portIf links [NUM_PORTS] ();

  for (genvar i = 0; i < NUM_PORTS; i++)
  begin : genPort
    inputPort #(
      .FIFO_DEPTH(FIFO_DEPTH)
    ) inputPort_i (
      .clk(clk),
      .rst(rst),
      .wrFlit(inFlit[i]),
      .wr(inWrite[i]),
      .full(inFull[i]),
      .port(links[i])
    );
  end

  switchArbiter switchArbiter_i (
    .clk(clk),
    .rst(rst),
    .ports(links)
  );

  crossbar crossbar_i (
    .clk(clk),
    .rst(rst),
    .ports(links),
    .outFlit(outFlit),
    .outValid(outValid)
  );

endmodule

// File: sim.f
flitPkg.sv
arbPkg.sv
portIf.sv
inputPort.sv
holdTimer.sv
switchArbiter.sv
crossbar.sv
routerTop.sv
routerChecker.sv
routerTb.sv

// File: switchArbiter.sv
module switchArbiter
  import flitPkg::*;
  import arbPkg::*;
(
  input logic clk,
  input logic rst,
  portIf.dst ports [NUM_PORTS]
);

  arbState_t state;
  arbState_t nextState;
  portMask_t reqVec;
  portMask_t headerVec;
  portMask_t holdVec;
  portMask_t timesUp;
  portIdx_t holderIdx;

  function automatic arbState_t grantState(portIdx_t idx);
    return arbState_t'(6'b000010 << idx);
  endfunction

  // Scans span ports from first onward, wrapping from S back to L.
  // The lowest offset that requests wins.
  function automatic arbState_t searchFrom(portMask_t reqs, int unsigned first,
                                           int unsigned span);
    arbState_t pick;
    int unsigned pos;
    pick = IDLE;
    for (int unsigned k = span; k > 0; k--)
    begin
      pos = (first + k - 1) % NUM_PORTS;
      if (reqs[pos])
      begin
        pick = grantState(portIdx_t'(pos));
      end
    end
    return pick;
  endfunction

  for (genvar i = 0; i < NUM_PORTS; i++)
  begin : genPort
    assign reqVec[i] = ports[i].req;
    // Only a real head flit may load a length, so an empty FIFO is masked.
    assign headerVec[i] = ports[i].req && (ports[i].flitId == HEADER_ID);
    assign holdVec[i] = (state == grantState(portIdx_t'(i)));

    // No flit moves in the cycle where the turn expires.
    assign ports[i].grant = holdVec[i] && reqVec[i] && !timesUp[i];

    holdTimer holdTimer_i (
      .clk(clk),
      .rst(rst),
      .isHeader(headerVec[i]),
      .hold(holdVec[i]),
      .length(ports[i].length),
      .timesUp(timesUp[i])
    );
  end

  always_comb
  begin
    holderIdx = '0;
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      if (holdVec[i])
      begin
        holderIdx = portIdx_t'(i);
      end
    end
  end

  // From idle the order is L, N, E, W, S. After a turn the search starts
  // at the port after the holder and leaves the holder out, so a lone
  // requester passes through IDLE before it gets a new turn.
  always_comb
  begin
    if (state == IDLE)
    begin
      nextState = searchFrom(reqVec, 0, NUM_PORTS);
    end
    else if (|(holdVec & reqVec & ~timesUp))
    begin
      nextState = state;
    end
    else
    begin
      nextState = searchFrom(reqVec, holderIdx + 1, NUM_PORTS - 1);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= IDLE;
    end
    else
    begin
      state <= nextState;
    end
  end

endmodule
